//--- build.f
src/csr_pkg.sv
src/csr_state_if.sv
src/trap_event_if.sv
src/csr_file.sv
src/csr_access.sv
src/trap_ctrl.sv
src/csr_unit_top.sv
verif/csr_unit_checker.sv
verif/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - src/csr_pkg.sv
  - src/csr_state_if.sv
  - src/trap_event_if.sv
  - src/csr_file.sv
  - src/csr_access.sv
  - src/trap_ctrl.sv
  - src/csr_unit_top.sv
  - target: test
    files:
      - verif/csr_unit_checker.sv
      - verif/csr_unit_tb.sv

//--- verif/csr_unit_tb.sv
module csr_unit_tb import csr_pkg::*; ();

    localparam int          CLK_HALF     = 4;
    localparam int          RESET_CYCLES = 3;
    localparam int          N_RANDOM     = 24;
    localparam int          RESP_TIMEOUT = 20;
    localparam logic [31:0] SEED         = 32'h3dd8;

    typedef struct packed {
        xlen_t rdata;
        logic  redirect;
        xlen_t redirect_pc;
        logic  trap_taken;
        priv_e mode;
    } expect_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      cmd_valid;
    csr_cmd_e  cmd;
    csr_addr_t csr_addr;
    xlen_t     operand;
    xlen_t     pc;
    logic      exc_valid;
    cause_t    exc_cause;
    logic      irq_mext;
    logic      irq_mtimer;
    logic      irq_msoft;
    logic      resp_valid;
    xlen_t     rdata;
    logic      redirect;
    xlen_t     redirect_pc;
    logic      trap_taken;
    priv_e     mode;
    xlen_t     satp;

    // Reference state, mip keeps only the supervisor bits
    csr_state_t m;
    expect_t    exp_q[$];
    string      step_q[$];
    string      cur_test;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         test_err_start = 0;

    csr_unit_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .csr_addr    (csr_addr),
        .operand     (operand),
        .pc          (pc),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause),
        .irq_mext    (irq_mext),
        .irq_mtimer  (irq_mtimer),
        .irq_msoft   (irq_msoft),
        .resp_valid  (resp_valid),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .trap_taken  (trap_taken),
        .mode        (mode),
        .satp        (satp)
    );

    bind csr_unit_top csr_unit_checker i_checker (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .resp_valid (resp_valid),
        .redirect   (redirect),
        .trap_taken (trap_taken)
    );

    always #CLK_HALF clk = ~clk;

    function automatic xlen_t mip_now();
        xlen_t v;
        v = m.mip & SIP_MASK;
        v[IRQ_MEI] = irq_mext;
        v[IRQ_MTI] = irq_mtimer;
        v[IRQ_MSI] = irq_msoft;
        return v;
    endfunction

    function automatic xlen_t read_csr(csr_addr_t a);
        xlen_t st;
        xlen_t v;
        st = {19'b0, m.status_mpp, 2'b0, m.status_spp, m.status_mpie, 1'b0,
              m.status_spie, 1'b0, m.status_mie, 1'b0, m.status_sie, 1'b0};
        case (a)
            ADDR_MSTATUS:  v = st;
            ADDR_SSTATUS:  v = st & SSTATUS_MASK;
            ADDR_MISA:     v = MISA_VALUE;
            ADDR_MEDELEG:  v = m.medeleg;
            ADDR_MIDELEG:  v = m.mideleg;
            ADDR_MIE:      v = m.mie;
            ADDR_SIE:      v = m.mie & SIP_MASK;
            ADDR_MIP:      v = mip_now();
            ADDR_SIP:      v = mip_now() & SIP_MASK;
            ADDR_MTVEC:    v = m.mtvec;
            ADDR_STVEC:    v = m.stvec;
            ADDR_MSCRATCH: v = m.mscratch;
            ADDR_SSCRATCH: v = m.sscratch;
            ADDR_MEPC:     v = m.mepc;
            ADDR_SEPC:     v = m.sepc;
            ADDR_MCAUSE:   v = m.mcause;
            ADDR_SCAUSE:   v = m.scause;
            ADDR_SATP:     v = m.satp;
            default:       v = '0;
        endcase
        return v;
    endfunction

    function automatic void write_csr(csr_addr_t a, xlen_t v);
        case (a)
            ADDR_MSTATUS: begin
                m.status_sie  = v[1];
                m.status_mie  = v[3];
                m.status_spie = v[5];
                m.status_mpie = v[7];
                m.status_spp  = v[8];
                m.status_mpp  = (v[12:11] == 2'b10) ? U_MODE : priv_e'(v[12:11]);
            end
            ADDR_SSTATUS: begin
                m.status_sie  = v[1];
                m.status_spie = v[5];
                m.status_spp  = v[8];
            end
            ADDR_MEDELEG:  m.medeleg  = v;
            ADDR_MIDELEG:  m.mideleg  = v & IRQ_MASK;
            ADDR_MIE:      m.mie      = v & IRQ_MASK;
            ADDR_SIE:      m.mie      = (m.mie & ~SIP_MASK) | (v & SIP_MASK);
            ADDR_MIP:      m.mip      = v & SIP_MASK;
            ADDR_SIP:      m.mip      = v & SIP_MASK;
            ADDR_MTVEC:    m.mtvec    = v;
            ADDR_STVEC:    m.stvec    = v;
            ADDR_MSCRATCH: m.mscratch = v;
            ADDR_SSCRATCH: m.sscratch = v;
            ADDR_MEPC:     m.mepc     = {v[31:2], 2'b00};
            ADDR_SEPC:     m.sepc     = {v[31:2], 2'b00};
            ADDR_MCAUSE:   m.mcause   = v;
            ADDR_SCAUSE:   m.scause   = v;
            ADDR_SATP:     m.satp     = v;
            default: begin
            end
        endcase
    endfunction

    // Expected response of one command, updates the reference state
    function automatic expect_t model_step(csr_cmd_e c, csr_addr_t a, xlen_t op, xlen_t p,
                                           logic ev, cause_t ec);
        int      order[6] = '{IRQ_MEI, IRQ_MSI, IRQ_MTI, IRQ_SEI, IRQ_SSI, IRQ_STI};
        expect_t e;
        xlen_t   pend;
        xlen_t   old_v;
        xlen_t   new_v;
        xlen_t   base;
        cause_t  cause;
        logic    irq;
        logic    to_m;
        logic    en;
        logic    is_exc;
        e = '0;
        irq = 1'b0;
        cause = '0;
        pend = mip_now() & m.mie;
        for (int i = 0; i < 6; i++) begin
            if (!irq && pend[order[i]]) begin
                irq = 1'b1;
                cause = cause_t'(order[i]);
            end
        end
        to_m = (m.mode == M_MODE) || !m.mideleg[cause];
        if (to_m) begin
            en = (m.mode == M_MODE) ? m.status_mie : 1'b1;
        end else begin
            en = (m.mode == S_MODE) ? m.status_sie : 1'b1;
        end
        is_exc = ev || (c == CMD_ECALL);
        if (is_exc) begin
            irq = 1'b0;
            cause = ev ? ec : CAUSE_ECALL_U + cause_t'(m.mode);
            to_m = (m.mode == M_MODE) || !m.medeleg[cause];
        end
        if (is_exc || (irq && en)) begin
            base = to_m ? m.mtvec : m.stvec;
            e.redirect = 1'b1;
            e.trap_taken = 1'b1;
            e.redirect_pc = {base[31:2], 2'b00};
            if (irq && base[1:0] == 2'b01) begin
                e.redirect_pc = e.redirect_pc + (xlen_t'(cause) << 2);
            end
            if (to_m) begin
                m.mepc = p;
                m.mcause = {irq, 26'b0, cause};
                m.status_mpie = m.status_mie;
                m.status_mie = 1'b0;
                m.status_mpp = m.mode;
                m.mode = M_MODE;
            end else begin
                m.sepc = p;
                m.scause = {irq, 26'b0, cause};
                m.status_spie = m.status_sie;
                m.status_sie = 1'b0;
                m.status_spp = (m.mode == S_MODE);
                m.mode = S_MODE;
            end
            if (irq && SIP_MASK[cause]) begin
                m.mip[cause] = 1'b0;
            end
        end else if (c == CMD_MRET) begin
            e.redirect = 1'b1;
            e.redirect_pc = m.mepc;
            m.status_mie = m.status_mpie;
            m.status_mpie = 1'b1;
            m.mode = m.status_mpp;
            m.status_mpp = U_MODE;
        end else if (c == CMD_SRET) begin
            e.redirect = 1'b1;
            e.redirect_pc = m.sepc;
            m.status_sie = m.status_spie;
            m.status_spie = 1'b1;
            m.mode = m.status_spp ? S_MODE : U_MODE;
            m.status_spp = 1'b0;
        end else if (c inside {CMD_READ, CMD_WRITE, CMD_SET, CMD_CLEAR}) begin
            old_v = read_csr(a);
            if (a[9:8] <= m.mode) begin
                e.rdata = old_v;
                if (c != CMD_READ && a[11:10] != 2'b11) begin
                    case (c)
                        CMD_WRITE: new_v = op;
                        CMD_SET:   new_v = old_v | op;
                        default:   new_v = old_v & ~op;
                    endcase
                    write_csr(a, new_v);
                end
            end
        end
        e.mode = m.mode;
        return e;
    endfunction

    task automatic check_value(input string step, input string field,
                               input xlen_t exp_v, input xlen_t act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("ERR %s %s %s expected %h actual %h", cur_test, step, field, exp_v, act_v);
        end
    endtask

    task automatic issue(input string step, input csr_cmd_e c, input csr_addr_t a,
                         input xlen_t op, input xlen_t p, input logic ev, input cause_t ec);
        int waited;
        exp_q.push_back(model_step(c, a, op, p, ev, ec));
        step_q.push_back(step);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        csr_addr  <= a;
        operand   <= op;
        pc        <= p;
        exc_valid <= ev;
        exc_cause <= ec;
        @(posedge clk);
        cmd_valid <= 1'b0;
        exc_valid <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("No response to %s %s within %0d cycles", cur_test, step, RESP_TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    task automatic csr_op(input string step, input csr_cmd_e c, input csr_addr_t a,
                          input xlen_t op);
        issue(step, c, a, op, 32'h0, 1'b0, '0);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %-22s %s", cur_test, (errors == test_err_start) ? "ok" : "mismatch");
    endtask

    // Responses are sampled mid-cycle
    initial begin : compare_responses
        expect_t e;
        string   step;
        forever begin
            @(negedge clk);
            if (resp_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response arrived with no command outstanding");
                end else begin
                    e = exp_q.pop_front();
                    step = step_q.pop_front();
                    check_value(step, "rdata", e.rdata, rdata);
                    check_value(step, "redirect", xlen_t'(e.redirect), xlen_t'(redirect));
                    check_value(step, "trap_taken", xlen_t'(e.trap_taken), xlen_t'(trap_taken));
                    check_value(step, "mode", xlen_t'(e.mode), xlen_t'(mode));
                    if (e.redirect) begin
                        check_value(step, "redirect_pc", e.redirect_pc, redirect_pc);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        csr_addr_t    addrs[4] = '{ADDR_MSCRATCH, ADDR_SSCRATCH, ADDR_MTVEC, ADDR_SATP};
        csr_cmd_e     ops[4] = '{CMD_READ, CMD_WRITE, CMD_SET, CMD_CLEAR};
        int unsigned  sel;
        void'($urandom(SEED));
        reset      <= 1'b1;
        cmd_valid  <= 1'b0;
        cmd        <= CMD_NONE;
        csr_addr   <= '0;
        operand    <= '0;
        pc         <= '0;
        exc_valid  <= 1'b0;
        exc_cause  <= '0;
        irq_mext   <= 1'b0;
        irq_mtimer <= 1'b0;
        irq_msoft  <= 1'b0;
        m = '0;
        m.mode = M_MODE;
        m.status_mpp = M_MODE;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        start_test("reset_values");
        csr_op("mstatus", CMD_READ, ADDR_MSTATUS, '0);
        csr_op("misa", CMD_READ, ADDR_MISA, '0);
        end_test();

        start_test("write_set_clear");
        for (int i = 0; i < N_RANDOM; i++) begin
            sel = $urandom % 4;
            csr_op($sformatf("op%0d", i), ops[sel], addrs[$urandom % 4], xlen_t'($urandom));
        end
        check_value("port", "satp", m.satp, satp);
        end_test();

        start_test("ecall_m_mret");
        csr_op("mtvec", CMD_WRITE, ADDR_MTVEC, 32'h0000_1000);
        issue("ecall", CMD_ECALL, '0, '0, 32'h0000_0200, 1'b0, '0);
        csr_op("mcause", CMD_READ, ADDR_MCAUSE, '0);
        csr_op("mepc", CMD_READ, ADDR_MEPC, '0);
        csr_op("mpp_to_u", CMD_CLEAR, ADDR_MSTATUS, 32'h0000_1800);
        issue("mret", CMD_MRET, '0, '0, 32'h0000_0300, 1'b0, '0);
        csr_op("mstatus_from_u", CMD_WRITE, ADDR_MSTATUS, 32'h0000_000a);
        end_test();

        // From U, the first ECALL still goes to M
        start_test("delegated_ecall_sret");
        issue("ecall_to_m", CMD_ECALL, '0, '0, 32'h0000_0400, 1'b0, '0);
        csr_op("mstatus_kept", CMD_READ, ADDR_MSTATUS, '0);
        csr_op("medeleg", CMD_WRITE, ADDR_MEDELEG, 32'h0000_0100);
        csr_op("stvec", CMD_WRITE, ADDR_STVEC, 32'h0000_2000);
        issue("mret_to_u", CMD_MRET, '0, '0, 32'h0000_0404, 1'b0, '0);
        issue("ecall_to_s", CMD_ECALL, '0, '0, 32'h0000_0500, 1'b0, '0);
        csr_op("scause", CMD_READ, ADDR_SCAUSE, '0);
        csr_op("sstatus", CMD_READ, ADDR_SSTATUS, '0);
        issue("sret", CMD_SRET, '0, '0, 32'h0000_2004, 1'b0, '0);
        end_test();

        start_test("irq_and_exception");
        issue("exc_to_m", CMD_NONE, '0, '0, 32'h0000_0600, 1'b1, 5'd2);
        csr_op("mtvec_vec", CMD_WRITE, ADDR_MTVEC, 32'h0000_3001);
        csr_op("mtie", CMD_WRITE, ADDR_MIE, 32'h0000_0080);
        csr_op("mie_on", CMD_SET, ADDR_MSTATUS, 32'h0000_0008);
        @(posedge clk);
        irq_mtimer <= 1'b1;
        // Let the level reach mip
        repeat (2) @(posedge clk);
        csr_op("timer_irq", CMD_READ, ADDR_MSCRATCH, '0);
        csr_op("mcause_irq", CMD_READ, ADDR_MCAUSE, '0);
        csr_op("mie_again", CMD_SET, ADDR_MSTATUS, 32'h0000_0008);
        issue("exc_wins", CMD_NONE, '0, '0, 32'h0000_0700, 1'b1, 5'd2);
        csr_op("mcause_exc", CMD_READ, ADDR_MCAUSE, '0);
        @(posedge clk);
        irq_mtimer <= 1'b0;
        end_test();

        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, i_dut.i_checker.fail_count);
        if (errors == 0 && i_dut.i_checker.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/csr_unit_checker.sv
module csr_unit_checker (
    input logic clk,
    input logic reset,
    input logic cmd_valid,
    input logic resp_valid,
    input logic redirect,
    input logic trap_taken
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Fixed one-cycle response latency
    a_resp_after_cmd: assert property (
        @(posedge clk) disable iff (reset) cmd_valid |=> resp_valid
    ) else begin
        fail_count++;
        $error("resp_valid missing one cycle after cmd_valid");
    end

    a_resp_only_after_cmd: assert property (
        @(posedge clk) disable iff (reset) resp_valid |-> $past(cmd_valid)
    ) else begin
        fail_count++;
        $error("resp_valid without a command in the previous cycle");
    end

    a_redirect_in_resp: assert property (
        @(posedge clk) disable iff (reset) (redirect || trap_taken) |-> resp_valid
    ) else begin
        fail_count++;
        $error("redirect or trap_taken high outside a response");
    end

    a_trap_redirects: assert property (
        @(posedge clk) disable iff (reset) trap_taken |-> redirect
    ) else begin
        fail_count++;
        $error("trap_taken high without redirect");
    end

    // Registered outputs come out of reset low
    a_quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> (!resp_valid && !redirect && !trap_taken)
    ) else begin
        fail_count++;
        $error("response outputs not low in the cycle after reset");
    end

endmodule

//--- src/csr_unit_top.sv
module csr_unit_top import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      cmd_valid,
    input  csr_cmd_e  cmd,
    input  csr_addr_t csr_addr,
    input  xlen_t     operand,
    input  xlen_t     pc,
    input  logic      exc_valid,
    input  cause_t    exc_cause,
    input  logic      irq_mext,
    input  logic      irq_mtimer,
    input  logic      irq_msoft,
    output logic      resp_valid,
    output xlen_t     rdata,
    output logic      redirect,
    output xlen_t     redirect_pc,
    output logic      trap_taken,
    output priv_e     mode,
    output xlen_t     satp
);

    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;

    csr_state_if  i_state_if ();
    trap_event_if i_trap_if ();

    csr_file i_csr_file (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .irq_mext   (irq_mext),
        .irq_mtimer (irq_mtimer),
        .irq_msoft  (irq_msoft),
        .state      (i_state_if.owner),
        .trap_evt   (i_trap_if.sink)
    );

    csr_access i_csr_access (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .csr_addr   (csr_addr),
        .operand    (operand),
        .state      (i_state_if.viewer),
        .trap_evt   (i_trap_if.sink),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .resp_valid (resp_valid),
        .rdata      (rdata)
    );

    trap_ctrl i_trap_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .pc          (pc),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause),
        .state       (i_state_if.viewer),
        .trap_evt    (i_trap_if.source),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .trap_taken  (trap_taken)
    );

    // Current mode and translation root for the MMU
    assign mode = i_state_if.state.mode;
    assign satp = i_state_if.state.satp;

endmodule

//--- src/trap_ctrl.sv
module trap_ctrl import csr_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          cmd_valid,
    input  csr_cmd_e      cmd,
    input  xlen_t         pc,
    input  logic          exc_valid,
    input  cause_t        exc_cause,
    csr_state_if.viewer   state,
    trap_event_if.source  trap_evt,
    output logic          redirect,
    output xlen_t         redirect_pc,
    output logic          trap_taken
);

    csr_state_t s;
    xlen_t      pend;
    logic       irq_any;
    cause_t     irq_cause;
    logic       irq_to_m;
    logic       irq_enabled;
    logic       is_exc;
    cause_t     exc_code;
    xlen_t      tvec;
    xlen_t      vec_pc;

    assign s    = state.state;
    assign pend = s.mip & s.mie;

    // Fixed priority MEI, MSI, MTI, SEI, SSI, STI
    always_comb begin
        irq_any = 1'b1;
        if (pend[IRQ_MEI]) begin
            irq_cause = CAUSE_MEI;
        end else if (pend[IRQ_MSI]) begin
            irq_cause = CAUSE_MSI;
        end else if (pend[IRQ_MTI]) begin
            irq_cause = CAUSE_MTI;
        end else if (pend[IRQ_SEI]) begin
            irq_cause = CAUSE_SEI;
        end else if (pend[IRQ_SSI]) begin
            irq_cause = CAUSE_SSI;
        end else if (pend[IRQ_STI]) begin
            irq_cause = CAUSE_STI;
        end else begin
            irq_any   = 1'b0;
            irq_cause = '0;
        end
    end

    assign irq_to_m = (s.mode == M_MODE) || !s.mideleg[irq_cause];

    // Lower modes never mask interrupts aimed at a higher one
    assign irq_enabled = irq_to_m ? ((s.mode == M_MODE) ? s.status_mie : 1'b1)
                                  : ((s.mode == S_MODE) ? s.status_sie : 1'b1);

    assign is_exc   = exc_valid || (cmd == CMD_ECALL);
    assign exc_code = exc_valid ? exc_cause : CAUSE_ECALL_U + cause_t'(s.mode);

    assign trap_evt.take_trap = cmd_valid && (is_exc || (irq_any && irq_enabled));
    assign trap_evt.is_irq    = !is_exc;
    assign trap_evt.cause     = is_exc ? exc_code : irq_cause;
    assign trap_evt.to_mmode  = is_exc ? ((s.mode == M_MODE) || !s.medeleg[exc_code]) : irq_to_m;
    assign trap_evt.epc       = pc;
    assign trap_evt.do_mret   = cmd_valid && (cmd == CMD_MRET) && !trap_evt.take_trap;
    assign trap_evt.do_sret   = cmd_valid && (cmd == CMD_SRET) && !trap_evt.take_trap;

    // Vectoring applies to interrupts only
    assign tvec   = trap_evt.to_mmode ? s.mtvec : s.stvec;
    assign vec_pc = {tvec[31:2], 2'b00} +
                    ((tvec_mode_e'(tvec[1:0]) == TVEC_VECTORED && trap_evt.is_irq)
                     ? (xlen_t'(trap_evt.cause) << 2) : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect   <= 1'b0;
            trap_taken <= 1'b0;
        end else begin
            redirect   <= trap_evt.take_trap || trap_evt.do_mret || trap_evt.do_sret;
            trap_taken <= trap_evt.take_trap;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_evt.take_trap) begin
            redirect_pc <= vec_pc;
        end else if (trap_evt.do_mret) begin
            redirect_pc <= s.mepc;
        end else if (trap_evt.do_sret) begin
            redirect_pc <= s.sepc;
        end
    end

endmodule

//--- src/csr_access.sv
module csr_access import csr_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          cmd_valid,
    input  csr_cmd_e      cmd,
    input  csr_addr_t     csr_addr,
    input  xlen_t         operand,
    csr_state_if.viewer   state,
    trap_event_if.sink    trap_evt,
    output logic          wr_en,
    output csr_addr_t     wr_addr,
    output xlen_t         wr_data,
    output logic          resp_valid,
    output xlen_t         rdata
);

    csr_state_t s;
    logic       is_csr_op;
    logic       is_write_op;
    logic       can_read;
    logic       can_write;
    xlen_t      csr_value;
    xlen_t      read_value;

    assign s = state.state;

    assign is_csr_op   = cmd inside {CMD_READ, CMD_WRITE, CMD_SET, CMD_CLEAR};
    assign is_write_op = cmd inside {CMD_WRITE, CMD_SET, CMD_CLEAR};

    // Address bits 9:8 hold the lowest mode allowed, 11:10 == 3 is read-only
    assign can_read  = csr_addr[9:8] <= s.mode;
    assign can_write = can_read && (csr_addr[11:10] != 2'b11);

    always_comb begin
        case (csr_addr)
            ADDR_MSTATUS:  csr_value = pack_mstatus(s);
            ADDR_SSTATUS:  csr_value = pack_mstatus(s) & SSTATUS_MASK;
            ADDR_MISA:     csr_value = MISA_VALUE;
            ADDR_MEDELEG:  csr_value = s.medeleg;
            ADDR_MIDELEG:  csr_value = s.mideleg;
            ADDR_MIE:      csr_value = s.mie;
            ADDR_SIE:      csr_value = s.mie & SIP_MASK;
            ADDR_MIP:      csr_value = s.mip;
            ADDR_SIP:      csr_value = s.mip & SIP_MASK;
            ADDR_MTVEC:    csr_value = s.mtvec;
            ADDR_STVEC:    csr_value = s.stvec;
            ADDR_MSCRATCH: csr_value = s.mscratch;
            ADDR_SSCRATCH: csr_value = s.sscratch;
            ADDR_MEPC:     csr_value = s.mepc;
            ADDR_SEPC:     csr_value = s.sepc;
            ADDR_MCAUSE:   csr_value = s.mcause;
            ADDR_SCAUSE:   csr_value = s.scause;
            ADDR_SATP:     csr_value = s.satp;
            default:       csr_value = '0;
        endcase
    end

    assign read_value = can_read ? csr_value : '0;

    always_comb begin
        case (cmd)
            CMD_WRITE: wr_data = operand;
            CMD_SET:   wr_data = csr_value | operand;
            CMD_CLEAR: wr_data = csr_value & ~operand;
            default:   wr_data = csr_value;
        endcase
    end

    // A trap in the same command cancels the write
    assign wr_en   = cmd_valid && is_write_op && can_write && !trap_evt.take_trap;
    assign wr_addr = csr_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= cmd_valid;
        end
    end

    // Old value of the CSR, zero for traps and non-CSR commands
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            rdata <= (is_csr_op && !trap_evt.take_trap) ? read_value : '0;
        end
    end

endmodule

//--- src/csr_file.sv
module csr_file import csr_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          wr_en,
    input  csr_addr_t     wr_addr,
    input  xlen_t         wr_data,
    input  logic          irq_mext,
    input  logic          irq_mtimer,
    input  logic          irq_msoft,
    csr_state_if.owner    state,
    trap_event_if.sink    trap_evt
);

    csr_state_t r;
    xlen_t      mip_base;

    assign state.state = r;

    function automatic xlen_t merge(xlen_t old_val, xlen_t new_val, xlen_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // MPP value 2 is reserved
    function automatic priv_e legal_priv(logic [1:0] v);
        return (v == 2'b10) ? U_MODE : priv_e'(v);
    endfunction

    // Machine pending bits follow the input levels, supervisor bits are held
    always_comb begin
        mip_base          = r.mip & SIP_MASK;
        mip_base[IRQ_MEI] = irq_mext;
        mip_base[IRQ_MTI] = irq_mtimer;
        mip_base[IRQ_MSI] = irq_msoft;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r            <= '0;
            r.mode       <= M_MODE;
            r.status_mpp <= M_MODE;
        end else begin
            r.mip <= mip_base;
            if (trap_evt.take_trap) begin
                if (trap_evt.to_mmode) begin
                    r.mepc        <= trap_evt.epc;
                    r.mcause      <= {trap_evt.is_irq, 26'b0, trap_evt.cause};
                    r.status_mpie <= r.status_mie;
                    r.status_mie  <= 1'b0;
                    r.status_mpp  <= r.mode;
                    r.mode        <= M_MODE;
                end else begin
                    r.sepc        <= trap_evt.epc;
                    r.scause      <= {trap_evt.is_irq, 26'b0, trap_evt.cause};
                    r.status_spie <= r.status_sie;
                    r.status_sie  <= 1'b0;
                    r.status_spp  <= r.mode[0];
                    r.mode        <= S_MODE;
                end
                // Taken supervisor interrupt is acknowledged here
                if (trap_evt.is_irq && SIP_MASK[trap_evt.cause]) begin
                    r.mip <= mip_base & ~(xlen_t'(1) << trap_evt.cause);
                end
            end else if (trap_evt.do_mret) begin
                r.status_mie  <= r.status_mpie;
                r.status_mpie <= 1'b1;
                r.mode        <= r.status_mpp;
                r.status_mpp  <= U_MODE;
            end else if (trap_evt.do_sret) begin
                r.status_sie  <= r.status_spie;
                r.status_spie <= 1'b1;
                r.mode        <= priv_e'({1'b0, r.status_spp});
                r.status_spp  <= 1'b0;
            end else if (wr_en) begin
                case (wr_addr)
                    ADDR_MSTATUS: begin
                        r.status_sie  <= wr_data[STATUS_SIE];
                        r.status_mie  <= wr_data[STATUS_MIE];
                        r.status_spie <= wr_data[STATUS_SPIE];
                        r.status_mpie <= wr_data[STATUS_MPIE];
                        r.status_spp  <= wr_data[STATUS_SPP];
                        r.status_mpp  <= legal_priv(wr_data[STATUS_MPP +: 2]);
                    end
                    // Supervisor view touches only its own fields
                    ADDR_SSTATUS: begin
                        r.status_sie  <= wr_data[STATUS_SIE];
                        r.status_spie <= wr_data[STATUS_SPIE];
                        r.status_spp  <= wr_data[STATUS_SPP];
                    end
                    ADDR_MEDELEG:  r.medeleg  <= wr_data;
                    ADDR_MIDELEG:  r.mideleg  <= wr_data & IRQ_MASK;
                    ADDR_MIE:      r.mie      <= wr_data & IRQ_MASK;
                    ADDR_SIE:      r.mie      <= merge(r.mie, wr_data, SIP_MASK);
                    ADDR_MIP:      r.mip      <= merge(mip_base, wr_data, SIP_MASK);
                    ADDR_SIP:      r.mip      <= merge(mip_base, wr_data, SIP_MASK);
                    ADDR_MTVEC:    r.mtvec    <= wr_data;
                    ADDR_STVEC:    r.stvec    <= wr_data;
                    ADDR_MSCRATCH: r.mscratch <= wr_data;
                    ADDR_SSCRATCH: r.sscratch <= wr_data;
                    ADDR_MEPC:     r.mepc     <= {wr_data[31:2], 2'b00};
                    ADDR_SEPC:     r.sepc     <= {wr_data[31:2], 2'b00};
                    ADDR_MCAUSE:   r.mcause   <= wr_data;
                    ADDR_SCAUSE:   r.scause   <= wr_data;
                    ADDR_SATP:     r.satp     <= wr_data;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- src/trap_event_if.sv
interface trap_event_if import csr_pkg::*; ();

    logic   take_trap;
    logic   to_mmode;
    cause_t cause;
    // Set when cause is an interrupt code
    logic   is_irq;
    xlen_t  epc;
    logic   do_mret;
    logic   do_sret;

    modport source (
        output take_trap, to_mmode, cause, is_irq, epc, do_mret, do_sret
    );

    modport sink (
        input take_trap, to_mmode, cause, is_irq, epc, do_mret, do_sret
    );

endinterface

//--- src/csr_state_if.sv
interface csr_state_if import csr_pkg::*; ();

    // Architectural CSR state, updated once per clock by the register file
    csr_state_t state;

    modport owner (
        output state
    );

    modport viewer (
        input state
    );

endinterface

//--- src/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  cause_t;

    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } priv_e;

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_READ,
        CMD_WRITE,
        CMD_SET,
        CMD_CLEAR,
        CMD_ECALL,
        CMD_MRET,
        CMD_SRET
    } csr_cmd_e;

    typedef enum logic [11:0] {
        ADDR_SSTATUS  = 12'h100,
        ADDR_SIE      = 12'h104,
        ADDR_STVEC    = 12'h105,
        ADDR_SSCRATCH = 12'h140,
        ADDR_SEPC     = 12'h141,
        ADDR_SCAUSE   = 12'h142,
        ADDR_SIP      = 12'h144,
        ADDR_SATP     = 12'h180,
        ADDR_MSTATUS  = 12'h300,
        ADDR_MISA     = 12'h301,
        ADDR_MEDELEG  = 12'h302,
        ADDR_MIDELEG  = 12'h303,
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MIP      = 12'h344
    } csr_addr_e;

    typedef enum logic [1:0] {
        TVEC_DIRECT   = 2'd0,
        TVEC_VECTORED = 2'd1
    } tvec_mode_e;

    // Exception and interrupt codes
    localparam cause_t CAUSE_ECALL_U = 5'd8;
    localparam cause_t CAUSE_SSI     = 5'd1;
    localparam cause_t CAUSE_MSI     = 5'd3;
    localparam cause_t CAUSE_STI     = 5'd5;
    localparam cause_t CAUSE_MTI     = 5'd7;
    localparam cause_t CAUSE_SEI     = 5'd9;
    localparam cause_t CAUSE_MEI     = 5'd11;

    // MXL = 1, extensions A, I and M
    localparam xlen_t MISA_VALUE = 32'h4000_1101;

    localparam int STATUS_SIE  = 1;
    localparam int STATUS_MIE  = 3;
    localparam int STATUS_SPIE = 5;
    localparam int STATUS_MPIE = 7;
    localparam int STATUS_SPP  = 8;
    localparam int STATUS_MPP  = 11;

    // Bit positions in mip, mie and mideleg
    localparam int IRQ_SSI = 1;
    localparam int IRQ_MSI = 3;
    localparam int IRQ_STI = 5;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_SEI = 9;
    localparam int IRQ_MEI = 11;

    localparam xlen_t SSTATUS_MASK = 32'h0000_0122;
    localparam xlen_t SIP_MASK     = 32'h0000_0222;
    localparam xlen_t IRQ_MASK     = 32'h0000_0aaa;

    typedef struct packed {
        priv_e mode;
        priv_e status_mpp;
        logic  status_spp;
        logic  status_mpie;
        logic  status_spie;
        logic  status_mie;
        logic  status_sie;
        xlen_t medeleg;
        xlen_t mideleg;
        xlen_t mie;
        xlen_t mip;
        xlen_t mtvec;
        xlen_t stvec;
        xlen_t mscratch;
        xlen_t sscratch;
        xlen_t mepc;
        xlen_t sepc;
        xlen_t mcause;
        xlen_t scause;
        xlen_t satp;
    } csr_state_t;

    // Assemble the architectural mstatus word from the stored fields
    function automatic xlen_t pack_mstatus(csr_state_t s);
        xlen_t v;
        v = '0;
        v[STATUS_SIE]       = s.status_sie;
        v[STATUS_MIE]       = s.status_mie;
        v[STATUS_SPIE]      = s.status_spie;
        v[STATUS_MPIE]      = s.status_mpie;
        v[STATUS_SPP]       = s.status_spp;
        v[STATUS_MPP +: 2]  = s.status_mpp;
        return v;
    endfunction

endpackage
